//--- rtl/rv32i_types_pkg.sv
package rv32i_types_pkg;

    typedef logic [31:0] pc_t;                   // byte address of an instruction

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,                   // load upper immediate
        op_auipc = 7'b0010111,                   // add upper immediate to pc
        op_jal   = 7'b1101111,                   // jump and link, pc relative
        op_jalr  = 7'b1100111,                   // jump and link, register based
        op_br    = 7'b1100011,                   // conditional branches
        op_load  = 7'b0000011,                   // loads
        op_store = 7'b0100011,                   // stores
        op_imm   = 7'b0010011,                   // register-immediate alu ops
        op_reg   = 7'b0110011                    // register-register alu ops
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,                           // signed compare
        bge  = 3'b101,                           // signed compare
        bltu = 3'b110,                           // unsigned compare
        bgeu = 3'b111                            // unsigned compare
    } branch_funct3_t;

    typedef struct packed {
        logic          imm_12;                   // sign bit of the branch offset
        logic [5:0]    imm_10_5;
        logic [4:0]    rs2;
        logic [4:0]    rs1;
        logic [2:0]    funct3;                   // branch condition
        logic [3:0]    imm_4_1;
        logic          imm_11;
        rv32i_opcode_t opcode;
    } b_fmt_t;

    // upper 12 bits double as the i-type immediate of jalr
    typedef struct packed {
        logic          imm_20;                   // sign bit, also i-imm bit 11
        logic [9:0]    imm_10_1;                 // also i-imm bits 10:1
        logic          imm_11;                   // also i-imm bit 0
        logic [7:0]    imm_19_12;
        logic [4:0]    rd;
        rv32i_opcode_t opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b_fmt;                           // conditional branch view
        j_fmt_t j_fmt;                           // jal view, jalr immediate view
    } rv32i_inst_t;

    localparam logic [31:0] nop_inst = 32'h0000_0013;   // addi x0, x0, 0

    function automatic pc_t b_imm(input rv32i_inst_t ir);
        return {{20{ir.b_fmt.imm_12}}, ir.b_fmt.imm_11, ir.b_fmt.imm_10_5,
                ir.b_fmt.imm_4_1, 1'b0};         // offsets are halfword aligned
    endfunction

    function automatic pc_t j_imm(input rv32i_inst_t ir);
        return {{12{ir.j_fmt.imm_20}}, ir.j_fmt.imm_19_12, ir.j_fmt.imm_11,
                ir.j_fmt.imm_10_1, 1'b0};
    endfunction

    function automatic pc_t i_imm(input rv32i_inst_t ir);
        return {{20{ir.j_fmt.imm_20}}, ir.j_fmt.imm_20, ir.j_fmt.imm_10_1,
                ir.j_fmt.imm_11};                // bits [31:20] of the word
    endfunction

endpackage

//--- rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // pc mux select, driven from execute
    typedef enum logic {
        pc_predict  = 1'b0,                      // fetch picks its own next pc
        pc_redirect = 1'b1                       // execute overrides the prediction
    } branchmux_sel_t;

    // first fetch address out of reset
    localparam rv32i_types_pkg::pc_t reset_pc = 32'h0000_0000;

    // step between sequential instructions, no compressed encodings
    localparam rv32i_types_pkg::pc_t inst_bytes = 32'd4;

endpackage

//--- rtl/pipe_stage_if.sv
`timescale 1ns/1ns

interface pipe_stage_if;
    import rv32i_types_pkg::*;

    logic        valid;                          // slot holds a live instruction
    pc_t         pc;                             // address the word was fetched from
    rv32i_inst_t ir;                             // instruction word, nop when flushed
    logic        predicted;                      // fetch went down the taken path

    // producing stage
    modport src (
        output valid,
        output pc,
        output ir,
        output predicted
    );

    // consuming stage
    modport dst (
        input valid,
        input pc,
        input ir,
        input predicted
    );

endinterface

//--- rtl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pipeline_en,    // pc holds when low
    input  pipe_ctrl_pkg::branchmux_sel_t branchmux_sel,  // from the resolver
    input  rv32i_types_pkg::pc_t          redirect_pc,    // corrected target
    input  logic [31:0]                   inst_rdata,     // combinational read data
    output rv32i_types_pkg::pc_t          inst_addr,      // imem address, the pc itself
    output logic                          inst_read,      // imem read strobe
    pipe_stage_if.src                     if_slot         // slot into if/id
);
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    pc_t         pc_q;                           // program counter
    pc_t         pc_next;                        // pc mux output
    pc_t         seq_pc;                         // fall-through address
    pc_t         br_target;                      // pc + b-immediate
    pc_t         jal_target;                     // pc + j-immediate
    rv32i_inst_t fetch_ir;                       // fetched word, both views
    logic        predict_taken;                  // static predictor decision
    logic        redirecting;                    // execute overrides this cycle

    assign fetch_ir    = inst_rdata;             // reinterpret as union
    assign redirecting = (branchmux_sel == pc_redirect);

    // candidate next addresses, all from the current pc
    assign seq_pc     = pc_q + inst_bytes;
    assign br_target  = pc_q + b_imm(fetch_ir);
    assign jal_target = pc_q + j_imm(fetch_ir);

    // static predictor: conditional branches and jal go taken,
    // jalr and everything else fall through until execute says otherwise
    always_comb begin
        predict_taken = 1'b0;
        case (fetch_ir.b_fmt.opcode)
            op_br:   predict_taken = 1'b1;       // backward or forward, always taken
            op_jal:  predict_taken = 1'b1;       // unconditional, target known here
            default: predict_taken = 1'b0;
        endcase
    end

    // pc mux
    always_comb begin
        pc_next = seq_pc;                        // default sequential
        if (redirecting) begin
            pc_next = redirect_pc;               // mispredict or jalr from execute
        end else if (predict_taken) begin
            if (fetch_ir.b_fmt.opcode == op_jal) begin
                pc_next = jal_target;
            end else begin
                pc_next = br_target;
            end
        end
    end

    // pc register, loads only on enabled cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= reset_pc;
        end else if (pipeline_en) begin
            pc_q <= pc_next;
        end
    end

    assign inst_addr = pc_q;                     // no wait states, address is the pc
    assign inst_read = 1'b1;                     // a fetch every cycle

    // outgoing slot, killed when execute redirects
    assign if_slot.valid     = !redirecting;
    assign if_slot.pc        = pc_q;
    assign if_slot.ir        = fetch_ir;
    assign if_slot.predicted = predict_taken && !redirecting;

endmodule

//--- rtl/pipe_buffer.sv
`timescale 1ns/1ns

module pipe_buffer (
    input  logic      clk,
    input  logic      reset,
    input  logic      pipeline_en,               // stall when low
    input  logic      flush,                     // replace slot with a bubble
    pipe_stage_if.dst d,                         // slot from the older stage
    pipe_stage_if.src q                          // slot to the younger stage
);
    import rv32i_types_pkg::*;

    logic bubble;                                // load an invalid nop slot

    assign bubble = flush || !d.valid;

    // control part of the slot
    always_ff @(posedge clk) begin
        if (reset) begin
            q.valid     <= 1'b0;
            q.predicted <= 1'b0;
            q.ir        <= nop_inst;             // ex sees a clean nop out of reset
        end else if (pipeline_en) begin
            if (bubble) begin
                q.valid     <= 1'b0;
                q.predicted <= 1'b0;
                q.ir        <= nop_inst;
            end else begin
                q.valid     <= 1'b1;
                q.predicted <= d.predicted;
                q.ir        <= d.ir;
            end
        end
    end

    // pc travels along even for bubbles
    always_ff @(posedge clk) begin
        if (pipeline_en) begin
            q.pc <= d.pc;
        end
    end

endmodule

//--- rtl/branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver (
    pipe_stage_if.dst                     ex_slot,        // instruction in execute
    input  logic                          pipeline_en,    // no redirect on a stall
    input  logic [31:0]                   rs1_data,       // operand a
    input  logic [31:0]                   rs2_data,       // operand b
    output pipe_ctrl_pkg::branchmux_sel_t branchmux_sel,  // pc mux select for fetch
    output rv32i_types_pkg::pc_t          redirect_pc,    // corrected fetch address
    output logic                          flush           // kill if/id and id/ex
);
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    logic  is_br;                                // valid conditional branch
    logic  is_jalr;                              // valid jalr
    logic  br_taken;                             // actual branch outcome
    logic  br_mispredict;                        // outcome differs from fetch
    logic  redirect;                             // ungated redirect request
    pc_t   fall_target;                          // pc + 4
    pc_t   taken_target;                         // pc + b-immediate
    pc_t   jalr_sum;                             // rs1 + i-immediate
    pc_t   target;                               // selected correction

    assign is_br   = ex_slot.valid && (ex_slot.ir.b_fmt.opcode == op_br);
    assign is_jalr = ex_slot.valid && (ex_slot.ir.j_fmt.opcode == op_jalr);

    // branch condition by funct3
    always_comb begin
        case (branch_funct3_t'(ex_slot.ir.b_fmt.funct3))
            beq:     br_taken = (rs1_data == rs2_data);
            bne:     br_taken = (rs1_data != rs2_data);
            blt:     br_taken = ($signed(rs1_data) <  $signed(rs2_data));
            bge:     br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            bltu:    br_taken = (rs1_data <  rs2_data);
            bgeu:    br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0;            // reserved codes never branch
        endcase
    end

    assign br_mispredict = is_br && (br_taken != ex_slot.predicted);

    // correction targets
    assign fall_target  = ex_slot.pc + inst_bytes;
    assign taken_target = ex_slot.pc + b_imm(ex_slot.ir);
    assign jalr_sum     = rs1_data + i_imm(ex_slot.ir);

    always_comb begin
        target = fall_target;
        if (is_jalr) begin
            target = {jalr_sum[31:1], 1'b0};     // lsb cleared per the isa
        end else if (br_taken) begin
            target = taken_target;               // predicted not taken, went taken
        end
    end

    assign redirect = br_mispredict || is_jalr;  // jalr is never predicted in fetch

    // outputs only act on enabled cycles
    assign branchmux_sel = (redirect && pipeline_en) ? pc_redirect : pc_predict;
    assign redirect_pc   = (redirect && pipeline_en) ? target : '0;
    assign flush         = redirect && pipeline_en;

endmodule

//--- rtl/rv32i_frontend.sv
`timescale 1ns/1ns

module rv32i_frontend (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         pipeline_en,   // global stall, low holds
    input  logic [31:0]                  inst_rdata,    // imem data, same cycle
    input  logic [31:0]                  rs1_data,      // operands of the ex instruction
    input  logic [31:0]                  rs2_data,
    output rv32i_types_pkg::pc_t         inst_addr,     // imem address
    output logic                         inst_read,     // imem read strobe
    output logic                         ex_valid,      // ex slot holds a live instruction
    output rv32i_types_pkg::pc_t         ex_pc,
    output rv32i_types_pkg::rv32i_inst_t ex_ir,
    output logic                         redirect       // execute corrected the fetch path
);
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    branchmux_sel_t branchmux_sel;               // resolver to pc mux
    pc_t            redirect_pc;                 // resolver target
    logic           flush;                       // kills both buffers

    pipe_stage_if if_slot ();                    // fetch to if/id
    pipe_stage_if id_slot ();                    // if/id to id/ex
    pipe_stage_if ex_slot ();                    // id/ex to resolver

    fetch_stage i_fetch (
        .clk           (clk),
        .reset         (reset),
        .pipeline_en   (pipeline_en),
        .branchmux_sel (branchmux_sel),
        .redirect_pc   (redirect_pc),
        .inst_rdata    (inst_rdata),
        .inst_addr     (inst_addr),
        .inst_read     (inst_read),
        .if_slot       (if_slot.src)
    );

    pipe_buffer i_if_id (
        .clk         (clk),
        .reset       (reset),
        .pipeline_en (pipeline_en),
        .flush       (flush),
        .d           (if_slot.dst),
        .q           (id_slot.src)
    );

    pipe_buffer i_id_ex (
        .clk         (clk),
        .reset       (reset),
        .pipeline_en (pipeline_en),
        .flush       (flush),
        .d           (id_slot.dst),
        .q           (ex_slot.src)
    );

    branch_resolver i_resolver (
        .ex_slot       (ex_slot.dst),
        .pipeline_en   (pipeline_en),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .branchmux_sel (branchmux_sel),
        .redirect_pc   (redirect_pc),
        .flush         (flush)
    );

    // ex slot out to the rest of the pipeline
    assign ex_valid = ex_slot.valid;
    assign ex_pc    = ex_slot.pc;
    assign ex_ir    = ex_slot.ir;
    assign redirect = flush;                     // same strobe that kills the buffers

endmodule

//--- tests/frontend_asserts.sv
`timescale 1ns/1ns

module frontend_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 pipeline_en,
    input logic                 inst_read,
    input rv32i_types_pkg::pc_t inst_addr,
    input logic                 ex_valid,
    input logic                 redirect,
    input rv32i_types_pkg::pc_t redirect_pc   // resolver target inside the top level
);

    logic [1:0] bubbles_left;                 // enabled cycles the ex slot stays empty

    always_ff @(posedge clk) begin
        if (reset) begin
            bubbles_left <= 2'd0;
        end else if (redirect) begin
            bubbles_left <= 2'd2;             // both buffers were flushed
        end else if (pipeline_en && bubbles_left != 2'd0) begin
            bubbles_left <= bubbles_left - 2'd1;
        end
    end

    read_always_on: assert property (@(posedge clk) disable iff (reset) inst_read)
        else $error("inst_read low outside reset");

    flush_bubbles: assert property (@(posedge clk) disable iff (reset)
        (bubbles_left != 2'd0) |-> !ex_valid)
        else $error("ex_valid high within two enabled cycles of a redirect");

    redirect_lands: assert property (@(posedge clk) disable iff (reset)
        redirect |=> (inst_addr == $past(redirect_pc)))
        else $error("fetch did not go to the redirect target");

    stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
        !pipeline_en |=> $stable(inst_addr))
        else $error("pc moved during a stall");

endmodule

bind rv32i_frontend frontend_asserts i_frontend_asserts (
    .clk         (clk),
    .reset       (reset),
    .pipeline_en (pipeline_en),
    .inst_read   (inst_read),
    .inst_addr   (inst_addr),
    .ex_valid    (ex_valid),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
);

//--- tests/frontend_tb.sv
`timescale 1ns/1ns

module frontend_tb;
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    typedef enum {steer_random, steer_taken, steer_not_taken} steer_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        pipeline_en;
    logic [31:0] inst_rdata;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    pc_t         inst_addr;
    logic        inst_read;
    logic        ex_valid;
    pc_t         ex_pc;
    rv32i_inst_t ex_ir;
    logic        redirect;

    logic [31:0] imem [0:255];                   // 1 KiB program image
    steer_t      op_mode = steer_taken;          // branch operand policy
    logic        stall_mode = 1'b0;              // random pipeline_en stretches
    int          stall_left = 0;
    logic        checking = 1'b0;                // model compare armed
    logic        timed_out = 1'b0;
    int          test_idx = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    int          total_checks = 0;
    int          total_errors = 0;

    // reference copy of the pc and the two buffered slots
    pc_t         m_pc = reset_pc;
    logic        m_id_valid = 1'b0;
    pc_t         m_id_pc = '0;
    rv32i_inst_t m_id_ir = nop_inst;
    logic        m_id_pred = 1'b0;
    logic        m_ex_valid = 1'b0;
    pc_t         m_ex_pc = '0;
    rv32i_inst_t m_ex_ir = nop_inst;
    logic        m_ex_pred = 1'b0;
    pc_t         exp_next;
    logic        exp_redir;
    logic [31:0] fetched;

    rv32i_frontend i_rv32i_frontend (
        .clk         (clk),
        .reset       (reset),
        .pipeline_en (pipeline_en),
        .inst_rdata  (inst_rdata),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .inst_addr   (inst_addr),
        .inst_read   (inst_read),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_ir       (ex_ir),
        .redirect    (redirect)
    );

    always #10 clk = ~clk;                       // 20 ns period

    function automatic logic [31:0] fill_word(input pc_t a);
        return {a[31:20] ^ a[19:8] ^ a[11:0], 5'd0, 3'b000, 5'd1, op_imm};  // addi x1, x0, f(a)
    endfunction

    function automatic logic [31:0] mem_word(input pc_t a);
        if (a < 32'h400) begin
            return imem[a[9:2]];
        end
        return fill_word(a);                     // outside the image
    endfunction

    always_comb inst_rdata = mem_word(inst_addr);  // no wait states

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_jalr};
    endfunction

    function automatic pc_t b_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic pc_t j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic pc_t i_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [2:0] funct3_pick();
        case ($urandom % 6)
            0:       return beq;
            1:       return bne;
            2:       return blt;
            3:       return bge;
            4:       return bltu;
            default: return bgeu;
        endcase
    endfunction

    function automatic logic branch_outcome(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            beq:     return a == b;
            bne:     return a != b;
            blt:     return $signed(a) < $signed(b);
            bge:     return $signed(a) >= $signed(b);
            bltu:    return a < b;
            bgeu:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // next fetch address from the pc, the fetched word and the ex slot
    function automatic pc_t next_pc_model(input pc_t pc, input logic [31:0] word,
                                          input logic ex_v, input pc_t ex_at,
                                          input logic [31:0] ex_w, input logic ex_pred,
                                          input logic [31:0] a, input logic [31:0] b,
                                          input logic en, output logic redir);
        pc_t  jump;
        logic taken;
        redir = 1'b0;
        jump  = '0;
        taken = branch_outcome(ex_w[14:12], a, b);
        if (en && ex_v && ex_w[6:0] == op_br && taken != ex_pred) begin
            redir = 1'b1;
            jump  = taken ? ex_at + b_offset(ex_w) : ex_at + inst_bytes;
        end
        if (en && ex_v && ex_w[6:0] == op_jalr) begin
            redir = 1'b1;
            jump  = (a + i_offset(ex_w)) & ~32'h1;
        end
        if (!en) begin
            return pc;                           // stall holds the pc
        end
        if (redir) begin
            return jump;
        end
        if (word[6:0] == op_br) begin
            return pc + b_offset(word);          // predicted taken
        end
        if (word[6:0] == op_jal) begin
            return pc + j_offset(word);
        end
        return pc + inst_bytes;
    endfunction

    task automatic check_pc(input string what, input pc_t got, input pc_t exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input string what, input rv32i_inst_t got, input rv32i_inst_t exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);                          // away from the compare edge
        test_idx++;
        $display("test %0d, %s: %0d checks, %0d errors", test_idx, name, test_checks,
                 test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic wait_for_pc(input logic at_ex, input pc_t a, input int limit);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < limit) begin
            @(posedge clk);
            n++;
            hit = at_ex ? (ex_valid === 1'b1 && ex_pc === a) : (inst_addr === a);
        end
        if (!hit) begin
            $display("timed out after %0d cycles waiting for pc %h", limit, a);
            timed_out = 1'b1;
            test_errors++;
        end
    endtask

    task automatic count_jalrs(input int want, input int limit);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < want && n < limit) begin
            @(posedge clk);
            n++;
            if (redirect && ex_valid && ex_ir.j_fmt.opcode == op_jalr) begin
                seen++;
            end
        end
        if (seen < want) begin
            $display("timed out after %0d cycles with %0d of %0d jalr redirects", limit, seen,
                     want);
            timed_out = 1'b1;
            test_errors++;
        end
    endtask

    task automatic build_program();
        int room;
        int step;
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(pc_t'(i * 4));
        end
        imem[8]  = jal_word(5'd1, 21'h20);                  // 0x20 to 0x40
        imem[16] = branch_word(beq, 5'd1, 5'd2, 13'h10);    // 0x40 steered taken
        imem[20] = branch_word(beq, 5'd1, 5'd2, 13'h20);    // 0x50 steered not taken
        imem[24] = jalr_word(5'd1, 5'd5, 12'h010);          // into the random region
        for (int i = 64; i < 256; i++) begin
            room = 255 - i;
            step = (room < 16) ? room : 16;                 // forward targets stay inside
            case ($urandom % 10)
                0, 1: imem[i] = jalr_word(5'd1, 5'd5, 12'($urandom));
                2, 3, 4: if (room > 0) begin
                    imem[i] = branch_word(funct3_pick(), 5'd3, 5'd4,
                                          13'(4 * (1 + $urandom % step)));
                end
                5: if (room > 0) begin
                    imem[i] = jal_word(5'd0, 21'(4 * (1 + $urandom % step)));
                end
                default: ;
            endcase
        end
        imem[255] = jalr_word(5'd1, 5'd5, 12'h7f0);         // last word always leaves
    endtask

    // operands and stalls steered from the model's ex slot
    always @(negedge clk) begin
        if (stall_mode && stall_left == 0 && $urandom % 4 == 0) begin
            stall_left = 1 + $urandom % 6;
        end
        pipeline_en = (stall_left == 0);
        if (stall_left > 0) begin
            stall_left--;
        end
        rs1_data = $urandom;
        rs2_data = $urandom;
        if (m_ex_valid && m_ex_ir.j_fmt.opcode == op_jalr) begin
            rs1_data = pc_t'((64 + $urandom % 192) * 4) - i_offset(m_ex_ir) + ($urandom % 2);
        end else if (m_ex_valid && m_ex_ir.b_fmt.opcode == op_br) begin
            case (op_mode)
                steer_taken:     rs2_data = rs1_data;           // beq holds
                steer_not_taken: rs2_data = rs1_data ^ 32'd1;
                default: begin
                    if ($urandom % 4 == 0) begin
                        rs2_data = rs1_data;
                    end else if ($urandom % 2 == 0) begin
                        rs1_data = $urandom % 8 - 4;            // small values of either sign
                        rs2_data = $urandom % 8 - 4;
                    end
                end
            endcase
        end
    end

    // compare against the model and step it on enabled edges
    always @(posedge clk) begin
        if (checking) begin
            fetched  = mem_word(m_pc);
            exp_next = next_pc_model(m_pc, fetched, m_ex_valid, m_ex_pc, m_ex_ir, m_ex_pred,
                                     rs1_data, rs2_data, pipeline_en, exp_redir);
            check_pc("inst_addr", inst_addr, m_pc);
            check_flag("inst_read", inst_read, 1'b1);
            check_flag("ex_valid", ex_valid, m_ex_valid);
            check_inst("ex_ir", ex_ir, m_ex_ir);
            if (m_ex_valid) begin
                check_pc("ex_pc", ex_pc, m_ex_pc);
            end
            check_flag("redirect", redirect, exp_redir);
            if (pipeline_en) begin
                m_ex_valid = m_id_valid && !exp_redir;
                m_ex_pc    = m_id_pc;
                m_ex_ir    = m_ex_valid ? m_id_ir : nop_inst;
                m_ex_pred  = m_ex_valid && m_id_pred;
                m_id_valid = !exp_redir;
                m_id_pc    = m_pc;
                m_id_ir    = exp_redir ? nop_inst : fetched;
                m_id_pred  = !exp_redir && (fetched[6:0] == op_br || fetched[6:0] == op_jal);
                m_pc       = exp_next;
            end
        end
    end

    initial begin
        void'($urandom(75598));
        reset       = 1'b1;
        pipeline_en = 1'b1;
        rs1_data    = '0;
        rs2_data    = '0;
        build_program();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        checking = 1'b1;

        for (int k = 0; k < 8; k++) begin
            @(posedge clk);
            check_pc("sequential inst_addr", inst_addr, reset_pc + pc_t'(k) * inst_bytes);
        end
        finish_test("reset and sequential fetch");

        wait_for_pc(1'b0, 32'h20, 40);
        if (!timed_out) begin
            @(posedge clk);
            check_pc("jal target", inst_addr, 32'h20 + j_offset(mem_word(32'h20)));
            @(posedge clk);
            check_pc("branch target", inst_addr, 32'h40 + b_offset(mem_word(32'h40)));
            wait_for_pc(1'b1, 32'h40, 20);
            check_flag("redirect on taken branch", redirect, 1'b0);
            op_mode = steer_not_taken;
        end
        finish_test("predicted jal and taken branch");

        if (!timed_out) begin
            wait_for_pc(1'b1, 32'h50, 20);
            check_flag("redirect on not-taken branch", redirect, 1'b1);
            @(posedge clk);
            check_pc("fall-through after redirect", inst_addr, 32'h50 + inst_bytes);
            check_flag("ex_valid after flush", ex_valid, 1'b0);
            @(posedge clk);
            check_flag("ex_valid after flush", ex_valid, 1'b0);
            op_mode = steer_random;
        end
        finish_test("not-taken branch redirect");

        if (!timed_out) begin
            count_jalrs(40, 5000);
        end
        finish_test("jalr and random branches");

        if (!timed_out) begin
            stall_mode = 1'b1;
            count_jalrs(40, 10000);
            stall_mode = 1'b0;
        end
        finish_test("random stalls");

        $display("totals: %0d tests, %0d checks, %0d errors", test_idx, total_checks,
                 total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- rv32i_frontend.f
rtl/rv32i_types_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/pipe_stage_if.sv
rtl/fetch_stage.sv
rtl/pipe_buffer.sv
rtl/branch_resolver.sv
rtl/rv32i_frontend.sv
tests/frontend_asserts.sv
tests/frontend_tb.sv

//--- Bender.yml
package:
  name: rv32i_frontend

sources:
  - files:
      - rtl/rv32i_types_pkg.sv
      - rtl/pipe_ctrl_pkg.sv
      - rtl/pipe_stage_if.sv
      - rtl/fetch_stage.sv
      - rtl/pipe_buffer.sv
      - rtl/branch_resolver.sv
      - rtl/rv32i_frontend.sv
  - target: test
    files:
      - tests/frontend_asserts.sv
      - tests/frontend_tb.sv
